// File: core_defines.svh
// Build-time constants for the core
// The boot address must be word aligned, since the PC only steps by 4
// The register count is fixed by RV32I and 5-bit register indices

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// First fetch address after reset
`define CORE_BOOT_ADDR 32'h0000_0800

// Architectural integer registers, x0 included
`define CORE_NUM_REGS 32

// Upper bound in cycles from one request to its retirement
// A memory that stalls longer than this is treated as hung
`define CORE_FETCH_WAIT_LIMIT 64

`endif

// File: core_pkg.sv
// Shared types for the RV32I subset core
// Only the ALU subset and LUI are encoded in alu_op_e
// Trace fields follow RISC-V Formal naming, without order or mode fields

package core_pkg;

  // ----------------------------------------
  // Width types
  // ----------------------------------------
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] irq_vec_t;
  typedef logic [4:0]  irq_id_t;

  // ----------------------------------------
  // State machine and operation encodings
  // ----------------------------------------
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    IDLE_REQ,
    WAIT_GNT,
    WAIT_RVALID,
    EXEC
  } fetch_state_e;

  // ----------------------------------------
  // Structs between the stages
  // ----------------------------------------
  // Decoded operation, 53 bits
  typedef struct packed {
    alu_op_e  alu_op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    logic     imm_sel;   // Operand b from imm instead of rs2
    logic     we;        // Register write, already cleared for x0
    logic     illegal;
  } dec_op_t;

  // Retirement trace, one entry per instruction
  typedef struct packed {
    logic     valid;
    logic     trap;
    addr_t    pc;
    word_t    insn;
    reg_idx_t rd_addr;
    word_t    rd_wdata;
  } retire_t;

endpackage

// File: core_fetch.sv
// PC and instruction fetch over an OBI read port
// One request in flight at a time, no new request until retirement
// The PC always steps by 4, there is no redirection

`timescale 1ns/1ps

`include "core_defines.svh"

module core_fetch import core_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  word_t instr_rdata_i,
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  output addr_t pc_o,
  output word_t insn_o,
  output logic  exec_o
);

  fetch_state_e state_q;
  addr_t        pc_q;
  word_t        insn_q;

  // ----------------------------------------
  // Fetch state machine
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE_REQ;
      pc_q    <= `CORE_BOOT_ADDR;
    end else begin
      case (state_q)
        // Address phase, may finish in its first cycle
        IDLE_REQ, WAIT_GNT: begin
          state_q <= instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
        // Response phase
        WAIT_RVALID: begin
          if (instr_rvalid_i) begin
            state_q <= EXEC;
          end
        end
        // Single execute cycle, retire and step on to the next word
        EXEC: begin
          state_q <= IDLE_REQ;
          pc_q    <= pc_q + addr_t'(4);
        end
        default: state_q <= IDLE_REQ;
      endcase
    end
  end

  // Instruction word, captured on the rvalid edge
  always_ff @(posedge clk_i) begin
    if (state_q == WAIT_RVALID && instr_rvalid_i) begin
      insn_q <= instr_rdata_i;
    end
  end

  // Req and addr held steady until the grant edge
  assign instr_req_o  = (state_q == IDLE_REQ) || (state_q == WAIT_GNT);
  assign instr_addr_o = pc_q;

  // PC of the held instruction, unchanged until EXEC ends
  assign pc_o   = pc_q;
  assign insn_o = insn_q;
  assign exec_o = (state_q == EXEC);

endmodule

// File: core_decode.sv
// Decoder for the ALU subset of RV32I plus LUI
// Every other encoding is flagged illegal and never writes a register
// Purely combinational

`timescale 1ns/1ps

module core_decode import core_pkg::*; (
  input  word_t   insn_i,
  output dec_op_t dec_o
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;

  // Instruction fields
  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  // I immediate sign-extended from bit 31, U immediate in the upper 20 bits
  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_u = {insn_i[31:12], 12'b0};

  always_comb begin
    dec_o         = '0;
    dec_o.alu_op  = ALU_ADD;
    dec_o.rs1     = insn_i[19:15];
    dec_o.rs2     = insn_i[24:20];
    dec_o.rd      = insn_i[11:7];
    dec_o.imm     = imm_i;
    dec_o.illegal = 1'b1;

    case (opcode)
      // Register-register
      OPC_OP: begin
        dec_o.illegal = 1'b0;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec_o.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: dec_o.alu_op = ALU_SUB;
          {7'b0000000, 3'b100}: dec_o.alu_op = ALU_XOR;
          {7'b0000000, 3'b110}: dec_o.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: dec_o.alu_op = ALU_AND;
          default:              dec_o.illegal = 1'b1;
        endcase
      end
      // Register-immediate, funct7 bits belong to the immediate here
      OPC_OP_IMM: begin
        dec_o.imm_sel = 1'b1;
        dec_o.illegal = 1'b0;
        case (funct3)
          3'b000:  dec_o.alu_op = ALU_ADD;
          3'b100:  dec_o.alu_op = ALU_XOR;
          3'b110:  dec_o.alu_op = ALU_OR;
          3'b111:  dec_o.alu_op = ALU_AND;
          default: dec_o.illegal = 1'b1;
        endcase
      end
      // LUI passes the U immediate straight through
      OPC_LUI: begin
        dec_o.alu_op  = ALU_PASS_B;
        dec_o.imm     = imm_u;
        dec_o.imm_sel = 1'b1;
        dec_o.illegal = 1'b0;
      end
      default: dec_o.illegal = 1'b1;
    endcase

    // No write for traps or for rd = x0
    dec_o.we = !dec_o.illegal && (dec_o.rd != reg_idx_t'(0));
  end

endmodule

// File: core_execute.sv
// Single-cycle ALU for the supported subset
// No shifts, compares or flags, result only

`timescale 1ns/1ps

module core_execute import core_pkg::*; (
  input  dec_op_t dec_i,
  input  word_t   rs1_val_i,
  input  word_t   rs2_val_i,
  output word_t   result_o
);

  word_t op_a;
  word_t op_b;

  // Operand a is always rs1
  assign op_a = rs1_val_i;

  // Immediate forms and LUI take b from the decoded immediate
  assign op_b = dec_i.imm_sel ? dec_i.imm : rs2_val_i;

  always_comb begin
    case (dec_i.alu_op)
      ALU_ADD:    result_o = op_a + op_b;
      ALU_SUB:    result_o = op_a - op_b;
      ALU_AND:    result_o = op_a & op_b;
      ALU_OR:     result_o = op_a | op_b;
      ALU_XOR:    result_o = op_a ^ op_b;
      // LUI, rs1 ignored
      ALU_PASS_B: result_o = op_b;
      default:    result_o = '0;
    endcase
  end

endmodule

// File: core_result.sv
// Register file, write-back and retirement trace
// Two asynchronous read ports, one write port on the EXEC edge
// Trace reports rd_addr and rd_wdata as zero when nothing is written

`timescale 1ns/1ps

`include "core_defines.svh"

module core_result import core_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    exec_i,
  input  dec_op_t dec_i,
  input  word_t   result_i,
  input  addr_t   pc_i,
  input  word_t   insn_i,
  output word_t   rs1_val_o,
  output word_t   rs2_val_o,
  output retire_t retire_o
);

  word_t   regs_q [`CORE_NUM_REGS];
  retire_t retire_q;
  logic    wr_en;

  // ----------------------------------------
  // Register file
  // ----------------------------------------
  // Decode already drops writes to x0
  assign wr_en = exec_i && dec_i.we;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      regs_q[dec_i.rd] <= result_i;
    end
  end

  // x0 reads as zero whatever the array holds
  assign rs1_val_o = (dec_i.rs1 == reg_idx_t'(0)) ? word_t'(0) : regs_q[dec_i.rs1];
  assign rs2_val_o = (dec_i.rs2 == reg_idx_t'(0)) ? word_t'(0) : regs_q[dec_i.rs2];

  // ----------------------------------------
  // Retirement trace
  // ----------------------------------------
  // Valid pulses for one cycle after each EXEC
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      retire_q <= '0;
    end else begin
      retire_q.valid <= exec_i;
      if (exec_i) begin
        retire_q.trap     <= dec_i.illegal;
        retire_q.pc       <= pc_i;
        retire_q.insn     <= insn_i;
        retire_q.rd_addr  <= dec_i.we ? dec_i.rd : reg_idx_t'(0);
        retire_q.rd_wdata <= dec_i.we ? result_i : word_t'(0);
      end
    end
  end

  assign retire_o = retire_q;

endmodule

// File: core_irq_ctrl.sv
// Interrupt acknowledge at retirement
// Highest-numbered pending line wins, no masking or enable
// Sources must drop a line once it has been acknowledged

`timescale 1ns/1ps

module core_irq_ctrl import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  irq_vec_t irq_i,
  input  logic     retire_en_i,
  output logic     irq_ack_o,
  output irq_id_t  irq_id_o
);

  logic    irq_any;
  irq_id_t irq_top;

  // Top-down scan, first set line from bit 31 wins
  always_comb begin
    irq_any = 1'b0;
    irq_top = '0;
    for (int i = 31; i >= 0; i--) begin
      if (irq_i[i] && !irq_any) begin
        irq_any = 1'b1;
        irq_top = irq_id_t'(i);
      end
    end
  end

  // Ack registered on the retirement edge
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irq_ack_o <= 1'b0;
      irq_id_o  <= '0;
    end else begin
      irq_ack_o <= retire_en_i && irq_any;
      if (retire_en_i && irq_any) begin
        irq_id_o <= irq_top;
      end
    end
  end

endmodule

// File: core_wrap.sv
// Top level of the RV32I subset core
// Instruction port is read-only OBI, no data port
// Two interrupt sources are merged by OR into one 32-line vector

`timescale 1ns/1ps

module core_wrap import core_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // OBI instruction port
  input  logic       instr_gnt_i,
  input  logic       instr_rvalid_i,
  input  word_t      instr_rdata_i,
  output logic       instr_req_o,
  output addr_t      instr_addr_o,
  output logic       instr_we_o,
  output logic [3:0] instr_be_o,
  // Trace
  output retire_t    retire_o,
  // Interrupts
  input  irq_vec_t   irq_a_i,
  input  irq_vec_t   irq_b_i,
  output logic       irq_ack_o,
  output irq_id_t    irq_id_o
);

  addr_t    pc;
  word_t    insn;
  logic     exec;
  dec_op_t  dec_op;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    result;
  irq_vec_t irq_vec;

  // ----------------------------------------
  // Port tie-offs and interrupt merge
  // ----------------------------------------
  // Fetch only ever reads whole words
  assign instr_we_o = 1'b0;
  assign instr_be_o = '1;

  assign irq_vec = irq_a_i | irq_b_i;

  // ----------------------------------------
  // Core stages
  // ----------------------------------------
  core_fetch u_fetch (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .pc_o           (pc),
    .insn_o         (insn),
    .exec_o         (exec)
  );

  core_decode u_decode (
    .insn_i (insn),
    .dec_o  (dec_op)
  );

  core_execute u_execute (
    .dec_i     (dec_op),
    .rs1_val_i (rs1_val),
    .rs2_val_i (rs2_val),
    .result_o  (result)
  );

  core_result u_result (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .exec_i    (exec),
    .dec_i     (dec_op),
    .result_i  (result),
    .pc_i      (pc),
    .insn_i    (insn),
    .rs1_val_o (rs1_val),
    .rs2_val_o (rs2_val),
    .retire_o  (retire_o)
  );

  // Acks share the retirement edge
  core_irq_ctrl u_irq_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .irq_i       (irq_vec),
    .retire_en_i (exec),
    .irq_ack_o   (irq_ack_o),
    .irq_id_o    (irq_id_o)
  );

endmodule

// File: tb_clk_gen.sv
// Testbench clock and reset
// Clock period 100 ns, reset high from time zero for 3 rising edges
// Reset drops 1 ns after the third edge, so it never moves on an edge

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

// File: tb_core_wrap.sv
// Testbench for core_wrap running straight-line code from the boot address
// Memory model answers each fetch with random grant and rvalid delays
// Expected values come from a register model that follows RV32I
// The program reads a register only after it has written it

`timescale 1ns/1ps

`include "core_defines.svh"

module tb_core_wrap import core_pkg::*; ();

  localparam int DRV_DLY  = 1;
  localparam int MAX_ROWS = 32;
  localparam int TIMEOUT  = `CORE_FETCH_WAIT_LIMIT;

  // Instruction kinds in the table
  // K_ILL is encoded as an LW
  typedef enum logic [3:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_ANDI, K_ORI, K_XORI, K_LUI, K_ILL
  } op_kind_e;

  // One stimulus row
  typedef struct packed {
    op_kind_e    kind;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [19:0] imm;
    irq_vec_t    irq_a;
    irq_vec_t    irq_b;
    logic [1:0]  gnt_dly;
    logic [1:0]  rv_dly;
  } row_t;

  logic       clk;
  logic       rst;
  logic       instr_gnt;
  logic       instr_rvalid;
  word_t      instr_rdata;
  logic       instr_req;
  addr_t      instr_addr;
  logic       instr_we;
  logic [3:0] instr_be;
  retire_t    retire;
  irq_vec_t   irq_a;
  irq_vec_t   irq_b;
  logic       irq_ack;
  irq_id_t    irq_id;

  row_t  rows [MAX_ROWS];
  word_t imem [MAX_ROWS];
  word_t model [`CORE_NUM_REGS];
  int    n_rows;
  int    tests_run;
  int    check_cnt;
  int    err_cnt;
  logic  hung;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  core_wrap uut (
    .clk_i          (clk),
    .rst_i          (rst),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_we_o     (instr_we),
    .instr_be_o     (instr_be),
    .retire_o       (retire),
    .irq_a_i        (irq_a),
    .irq_b_i        (irq_b),
    .irq_ack_o      (irq_ack),
    .irq_id_o       (irq_id)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_val(input string name, input word_t got, input word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input op_kind_e kind, input int rd, input int rs1, input int rs2,
                         input int imm, input irq_vec_t ia, input irq_vec_t ib);
    row_t r;
    r.kind    = kind;
    r.rd      = reg_idx_t'(rd);
    r.rs1     = reg_idx_t'(rs1);
    r.rs2     = reg_idx_t'(rs2);
    r.imm     = 20'(imm);
    r.irq_a   = ia;
    r.irq_b   = ib;
    r.gnt_dly = 2'($urandom % 4);
    r.rv_dly  = 2'($urandom % 4);
    rows[n_rows] = r;
    n_rows++;
  endtask

  // RV32I encodings in the R, I and U formats
  function automatic word_t encode(input row_t r);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = (r.kind == K_SUB) ? 7'b0100000 : 7'b0000000;
    case (r.kind)
      K_ADD, K_SUB, K_ADDI: f3 = 3'b000;
      K_XOR, K_XORI:        f3 = 3'b100;
      K_OR, K_ORI:          f3 = 3'b110;
      K_AND, K_ANDI:        f3 = 3'b111;
      default:              f3 = 3'b010;
    endcase
    case (r.kind)
      K_ADD, K_SUB, K_AND, K_OR, K_XOR: return {f7, r.rs2, r.rs1, f3, r.rd, 7'b0110011};
      K_LUI:   return {r.imm, r.rd, 7'b0110111};
      // Load opcode lies outside the subset
      K_ILL:   return {r.imm[11:0], r.rs1, f3, r.rd, 7'b0000011};
      default: return {r.imm[11:0], r.rs1, f3, r.rd, 7'b0010011};
    endcase
  endfunction

  function automatic word_t read_model(input reg_idx_t idx);
    return (idx == '0) ? word_t'(0) : model[idx];
  endfunction

  function automatic word_t expected_result(input row_t r);
    word_t a;
    word_t b;
    word_t imm_i;
    a     = read_model(r.rs1);
    b     = read_model(r.rs2);
    imm_i = {{20{r.imm[11]}}, r.imm[11:0]};
    case (r.kind)
      K_ADD:   return a + b;
      K_SUB:   return a - b;
      K_AND:   return a & b;
      K_OR:    return a | b;
      K_XOR:   return a ^ b;
      K_ADDI:  return a + imm_i;
      K_ANDI:  return a & imm_i;
      K_ORI:   return a | imm_i;
      K_XORI:  return a ^ imm_i;
      K_LUI:   return {r.imm, 12'h000};
      default: return '0;
    endcase
  endfunction

  // Highest set line or -1 when none
  function automatic int highest_line(input irq_vec_t vec);
    int top;
    top = -1;
    for (int i = 0; i < 32; i++) begin
      if (vec[i]) begin
        top = i;
      end
    end
    return top;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #DRV_DLY;
  endtask

  task automatic wait_for_req(output logic ok);
    int n;
    n = 0;
    while (!instr_req && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    ok = instr_req;
  endtask

  task automatic wait_for_retire(output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TIMEOUT) begin
      next_cycle();
      n++;
      ok = retire.valid;
    end
  endtask

  // ----------------------------------------
  // One instruction from fetch to retirement
  // ----------------------------------------
  task automatic run_row(input int idx);
    row_t     r;
    addr_t    exp_pc;
    addr_t    word_idx;
    word_t    exp_data;
    reg_idx_t exp_rd;
    logic     exp_trap;
    logic     ok;
    int       top;
    int       errs_before;
    r           = rows[idx];
    errs_before = err_cnt;
    exp_pc      = `CORE_BOOT_ADDR + addr_t'(idx * 4);
    wait_for_req(ok);
    if (!ok) begin
      $display("Test %0d: no fetch request within %0d cycles", idx, TIMEOUT);
      hung = 1'b1;
      return;
    end
    // New lines join any still pending
    irq_a = irq_a | r.irq_a;
    irq_b = irq_b | r.irq_b;
    top   = highest_line(irq_a | irq_b);
    // Req and addr hold steady through every cycle before the grant
    check_val("instr_addr_o", instr_addr, exp_pc);
    repeat (r.gnt_dly) begin
      next_cycle();
      check_val("instr_req_o", word_t'(instr_req), 32'd1);
      check_val("instr_addr_o", instr_addr, exp_pc);
    end
    word_idx  = (instr_addr - `CORE_BOOT_ADDR) >> 2;
    instr_gnt = 1'b1;
    next_cycle();
    instr_gnt = 1'b0;
    // No new request while the response is pending
    check_val("instr_req_o", word_t'(instr_req), 32'd0);
    repeat (r.rv_dly) begin
      next_cycle();
      check_val("instr_req_o", word_t'(instr_req), 32'd0);
    end
    instr_rvalid = 1'b1;
    instr_rdata  = imem[word_idx[4:0]];
    next_cycle();
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    wait_for_retire(ok);
    if (!ok) begin
      $display("Test %0d: no retirement within %0d cycles", idx, TIMEOUT);
      hung = 1'b1;
      return;
    end
    // Nothing is written for traps or x0
    exp_trap = (r.kind == K_ILL);
    exp_rd   = (exp_trap || r.rd == '0) ? '0 : r.rd;
    exp_data = (exp_rd == '0) ? '0 : expected_result(r);
    check_val("retire_o.trap", word_t'(retire.trap), word_t'(exp_trap));
    check_val("retire_o.pc", retire.pc, exp_pc);
    check_val("retire_o.insn", retire.insn, imem[idx]);
    check_val("retire_o.rd_addr", word_t'(retire.rd_addr), word_t'(exp_rd));
    check_val("retire_o.rd_wdata", retire.rd_wdata, exp_data);
    check_val("instr_we_o", word_t'(instr_we), 32'd0);
    check_val("instr_be_o", word_t'(instr_be), 32'hF);
    check_val("irq_ack_o", word_t'(irq_ack), word_t'(top >= 0));
    if (top >= 0) begin
      check_val("irq_id_o", word_t'(irq_id), word_t'(top));
      // Both sources drop the acknowledged line
      irq_a = irq_a & ~(irq_vec_t'(1) << top);
      irq_b = irq_b & ~(irq_vec_t'(1) << top);
    end
    if (exp_rd != '0) begin
      model[exp_rd] = exp_data;
    end
    tests_run++;
    $display("Test %2d  pc %h  insn %h  %s", idx, exp_pc, imem[idx],
             (err_cnt == errs_before) ? "ok" : "FAILED");
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic build_table();
    add_row(K_ADDI, 1, 0, 0, 5, '0, '0);
    add_row(K_ADDI, 2, 0, 0, -3, '0, '0);
    add_row(K_ADD, 3, 1, 2, 0, '0, '0);
    // Lines 20, 7 and 3 pending and acked over three retirements
    add_row(K_SUB, 4, 1, 2, 0, 32'h0000_0080, 32'h0010_0008);
    add_row(K_LUI, 5, 0, 0, 'hABCDE, '0, '0);
    add_row(K_ORI, 6, 5, 0, 'h123, '0, '0);
    add_row(K_XORI, 7, 6, 0, -1, '0, '0);
    add_row(K_ANDI, 8, 7, 0, 'h7F0, '0, '0);
    // Top and bottom lines from different sources
    add_row(K_AND, 9, 6, 2, 0, 32'h8000_0000, 32'h0000_0001);
    add_row(K_OR, 10, 1, 5, 0, '0, '0);
    add_row(K_XOR, 11, 10, 6, 0, '0, '0);
    // Write to x0, then read it back
    add_row(K_ADDI, 0, 1, 0, 99, '0, '0);
    add_row(K_ADD, 12, 0, 1, 0, '0, '0);
    // Trap with rd x1 leaves x1 at 5
    add_row(K_ILL, 1, 0, 0, 0, '0, '0);
    add_row(K_ADDI, 13, 1, 0, 0, '0, '0);
    // Same line on both sources
    add_row(K_ADDI, 14, 2, 0, -2048, 32'h0000_0400, 32'h0000_0400);
    add_row(K_LUI, 15, 0, 0, 'hFFFFF, '0, '0);
    add_row(K_SUB, 16, 15, 14, 0, '0, '0);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int n;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    irq_a        = '0;
    irq_b        = '0;
    n_rows       = 0;
    tests_run    = 0;
    check_cnt    = 0;
    err_cnt      = 0;
    hung         = 1'b0;
    for (int i = 0; i < `CORE_NUM_REGS; i++) begin
      model[i] = '0;
    end
    void'($urandom(50177));
    build_table();
    for (int i = 0; i < n_rows; i++) begin
      imem[i] = encode(rows[i]);
    end
    // Wait for the release of reset
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (rst && n < TIMEOUT);
    #DRV_DLY;
    if (rst) begin
      $display("Reset was never released");
      hung = 1'b1;
    end
    check_val("retire_o.valid", word_t'(retire.valid), 32'd0);
    check_val("irq_ack_o", word_t'(irq_ack), 32'd0);
    for (int i = 0; i < n_rows && !hung; i++) begin
      run_row(i);
    end
    $display("Summary: %0d of %0d tests run, %0d checks, %0d errors",
             tests_run, n_rows, check_cnt, err_cnt);
    if (!hung && err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+.
core_pkg.sv
core_fetch.sv
core_decode.sv
core_execute.sv
core_result.sv
core_irq_ctrl.sv
core_wrap.sv
tb_clk_gen.sv
tb_core_wrap.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_core_wrap -f all.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "Result: FAIL"; exit 1; }
echo "Result: PASS"
